// File: verilog/manycore_cfg_pkg.sv
// manycore row configuration: default row sizes and index width helper
`default_nettype none

package manycore_cfg_pkg;

  // tiles sharing the bank
  localparam int num_tiles_default = 4;

  // data word width in bits
  localparam int data_width_default = 32;

  // words in the shared bank
  localparam int dmem_words_default = 16;

  // register stages on the reset path
  localparam int reset_depth_default = 3;

  // index width for a count of n items, never below one bit
  function automatic int safe_clog2(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

`default_nettype wire

// File: verilog/mem_op_pkg.sv
// memory operation encodings and shared bank state encoding
`default_nettype none

package mem_op_pkg;

  // request opcodes seen at the processor-side port
  typedef enum logic [1:0] {
    // returns the stored word
    op_load    = 2'b00,
    // writes the word, returns the written data
    op_store   = 2'b01,
    // adds to the word, returns the old value
    op_amo_add = 2'b10
  } e_mem_op;

  // bank sequencing after reset
  typedef enum logic [0:0] {
    // zeroing words one per cycle
    bank_clear = 1'b0,
    // serving requests
    bank_run   = 1'b1
  } e_bank_state;

endpackage

`default_nettype wire

// File: verilog/reset_pipe.sv
// reset pipe: asynchronous assert, synchronous release after a chain of flops
`timescale 1ns/1ps
`default_nettype none

module reset_pipe
  import manycore_cfg_pkg::*;
#(
  parameter int reset_depth_p = reset_depth_default
) (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic rst_n_o
);

  logic [reset_depth_p-1:0] chain_r;

  // ones shift in from stage 0 once the input reset is released
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      chain_r <= '0;
    end else begin
      chain_r[0] <= 1'b1;
      for (int i = 1; i < reset_depth_p; i++) begin
        chain_r[i] <= chain_r[i-1];
      end
    end
  end

  assign rst_n_o = chain_r[reset_depth_p-1];

endmodule

`default_nettype wire

// File: verilog/tile_endpoint.sv
// tile endpoint: holds one pending memory request and collects its tagged response
`timescale 1ns/1ps
`default_nettype none

module tile_endpoint
  import manycore_cfg_pkg::*;
  import mem_op_pkg::*;
#(
  parameter int tile_id_p     = 0,
  parameter int num_tiles_p   = num_tiles_default,
  parameter int data_width_p  = data_width_default,
  parameter int dmem_words_p  = dmem_words_default,
  localparam int tile_width_lp = safe_clog2(num_tiles_p),
  localparam int addr_width_lp = safe_clog2(dmem_words_p)
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // processor side
  input  logic                     req_v_i,
  input  e_mem_op                  req_op_i,
  input  logic [addr_width_lp-1:0] req_addr_i,
  input  logic [data_width_p-1:0]  req_data_i,
  output logic                     busy_o,

  // toward the arbiter
  output logic                     wait_o,
  input  logic                     grant_i,
  output e_mem_op                  pend_op_o,
  output logic [addr_width_lp-1:0] pend_addr_o,
  output logic [data_width_p-1:0]  pend_data_o,

  // response broadcast from the bank
  input  logic                     bank_resp_v_i,
  input  logic [tile_width_lp-1:0] bank_resp_tile_i,
  input  logic [data_width_p-1:0]  bank_resp_data_i,

  // response back to the processor
  output logic                     resp_v_o,
  output logic [data_width_p-1:0]  resp_data_o
);

  logic busy_r;
  logic wait_r;
  logic resp_hit;
  logic accept;

  // only the tile whose index is on the response bus takes it
  assign resp_hit = bank_resp_v_i && (bank_resp_tile_i == tile_width_lp'(tile_id_p));

  // busy drops in the same cycle the response shows up
  assign busy_o = busy_r && !resp_hit;
  assign accept = req_v_i && !busy_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_r <= 1'b0;
      wait_r <= 1'b0;
    end else if (accept) begin
      busy_r <= 1'b1;
      wait_r <= 1'b1;
    end else begin
      if (resp_hit) begin
        busy_r <= 1'b0;
      end
      // the arbiter has taken the request, stop asking
      if (grant_i) begin
        wait_r <= 1'b0;
      end
    end
  end

  // request payload, stable while busy
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pend_op_o   <= req_op_i;
      pend_addr_o <= req_addr_i;
      pend_data_o <= req_data_i;
    end
  end

  assign wait_o      = wait_r;
  assign resp_v_o    = resp_hit;
  assign resp_data_o = bank_resp_data_i;

endmodule

`default_nettype wire

// File: verilog/rr_arbiter.sv
// round-robin arbiter: picks one waiting tile per cycle and registers it to the bank
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter
  import manycore_cfg_pkg::*;
  import mem_op_pkg::*;
#(
  parameter int num_tiles_p   = num_tiles_default,
  parameter int data_width_p  = data_width_default,
  parameter int dmem_words_p  = dmem_words_default,
  localparam int tile_width_lp = safe_clog2(num_tiles_p),
  localparam int addr_width_lp = safe_clog2(dmem_words_p)
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic                                        enable_i,
  input  logic    [num_tiles_p-1:0]                   wait_i,
  output logic    [num_tiles_p-1:0]                   grant_o,
  input  e_mem_op [num_tiles_p-1:0]                   pend_op_i,
  input  logic    [num_tiles_p-1:0][addr_width_lp-1:0] pend_addr_i,
  input  logic    [num_tiles_p-1:0][data_width_p-1:0]  pend_data_i,
  output logic                                        bank_v_o,
  output e_mem_op                                     bank_op_o,
  output logic    [addr_width_lp-1:0]                 bank_addr_o,
  output logic    [data_width_p-1:0]                  bank_data_o,
  output logic    [tile_width_lp-1:0]                 bank_tile_o
);

  logic [tile_width_lp-1:0] ptr_r;
  logic [tile_width_lp-1:0] win_idx;
  logic                     found;

  // first waiting tile at or after the pointer, held off while the bank clears
  always_comb begin : pick
    int idx;
    grant_o = '0;
    found   = 1'b0;
    win_idx = '0;
    for (int i = 0; i < num_tiles_p; i++) begin
      idx = (int'(ptr_r) + i) % num_tiles_p;
      if (enable_i && !found && wait_i[idx]) begin
        found        = 1'b1;
        win_idx      = tile_width_lp'(idx);
        grant_o[idx] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_r    <= '0;
      bank_v_o <= 1'b0;
    end else begin
      bank_v_o <= found;
      // next search starts just past the winner
      if (found) begin
        if (win_idx == tile_width_lp'(num_tiles_p - 1)) begin
          ptr_r <= '0;
        end else begin
          ptr_r <= win_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (found) begin
      bank_op_o   <= pend_op_i[win_idx];
      bank_addr_o <= pend_addr_i[win_idx];
      bank_data_o <= pend_data_i[win_idx];
      bank_tile_o <= win_idx;
    end
  end

endmodule

`default_nettype wire

// File: verilog/mem_bank.sv
// shared data bank: load, store and atomic add with a tile-tagged response
`timescale 1ns/1ps
`default_nettype none

module mem_bank
  import manycore_cfg_pkg::*;
  import mem_op_pkg::*;
#(
  parameter int num_tiles_p   = num_tiles_default,
  parameter int data_width_p  = data_width_default,
  parameter int dmem_words_p  = dmem_words_default,
  localparam int tile_width_lp = safe_clog2(num_tiles_p),
  localparam int addr_width_lp = safe_clog2(dmem_words_p)
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     bank_v_i,
  input  e_mem_op                  bank_op_i,
  input  logic [addr_width_lp-1:0] bank_addr_i,
  input  logic [data_width_p-1:0]  bank_data_i,
  input  logic [tile_width_lp-1:0] bank_tile_i,
  output logic                     ready_o,
  output logic                     resp_v_o,
  output logic [tile_width_lp-1:0] resp_tile_o,
  output logic [data_width_p-1:0]  resp_data_o
);

  logic [data_width_p-1:0]  mem_r [dmem_words_p];
  e_bank_state              state_r;
  logic [addr_width_lp-1:0] clear_cnt_r;
  logic                     exec;
  logic [data_width_p-1:0]  old_word;
  logic                     wr_en;
  logic [data_width_p-1:0]  wr_data;
  logic [data_width_p-1:0]  rd_data;

  assign ready_o  = (state_r == bank_run);
  assign exec     = bank_v_i && ready_o;
  assign old_word = mem_r[bank_addr_i];

  // read-modify-write resolved within the cycle
  always_comb begin
    wr_en   = 1'b0;
    wr_data = bank_data_i;
    rd_data = old_word;
    case (bank_op_i)
      op_store: begin
        wr_en   = exec;
        rd_data = bank_data_i;
      end
      op_amo_add: begin
        wr_en   = exec;
        wr_data = old_word + bank_data_i;
      end
      default: begin
        wr_en = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r     <= bank_clear;
      clear_cnt_r <= '0;
      resp_v_o    <= 1'b0;
    end else begin
      resp_v_o <= exec;
      // one word zeroed per cycle, then run
      if (state_r == bank_clear) begin
        clear_cnt_r <= clear_cnt_r + 1'b1;
        if (clear_cnt_r == addr_width_lp'(dmem_words_p - 1)) begin
          state_r <= bank_run;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == bank_clear) begin
      mem_r[clear_cnt_r] <= '0;
    end else if (wr_en) begin
      mem_r[bank_addr_i] <= wr_data;
    end
    if (exec) begin
      resp_tile_o <= bank_tile_i;
      resp_data_o <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/manycore_row_top.sv
// manycore row top: tile endpoints sharing one data bank through a round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

module manycore_row_top
  import manycore_cfg_pkg::*;
  import mem_op_pkg::*;
#(
  parameter int num_tiles_p   = num_tiles_default,
  parameter int data_width_p  = data_width_default,
  parameter int dmem_words_p  = dmem_words_default,
  parameter int reset_depth_p = reset_depth_default,
  localparam int tile_width_lp = safe_clog2(num_tiles_p),
  localparam int addr_width_lp = safe_clog2(dmem_words_p)
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic    [num_tiles_p-1:0]                   req_v_i,
  input  e_mem_op [num_tiles_p-1:0]                   req_op_i,
  input  logic    [num_tiles_p-1:0][addr_width_lp-1:0] req_addr_i,
  input  logic    [num_tiles_p-1:0][data_width_p-1:0]  req_data_i,
  output logic    [num_tiles_p-1:0]                   busy_o,
  output logic    [num_tiles_p-1:0]                   resp_v_o,
  output logic    [num_tiles_p-1:0][data_width_p-1:0]  resp_data_o
);

  // pipelined reset shared by every sink in the row
  logic                                         row_rst_n;
  logic    [num_tiles_p-1:0]                    tile_wait;
  logic    [num_tiles_p-1:0]                    tile_grant;
  e_mem_op [num_tiles_p-1:0]                    pend_op;
  logic    [num_tiles_p-1:0][addr_width_lp-1:0] pend_addr;
  logic    [num_tiles_p-1:0][data_width_p-1:0]  pend_data;
  logic                                         bank_ready;
  logic                                         bank_v;
  e_mem_op                                      bank_op;
  logic    [addr_width_lp-1:0]                  bank_addr;
  logic    [data_width_p-1:0]                   bank_data;
  logic    [tile_width_lp-1:0]                  bank_tile;
  logic                                         bank_resp_v;
  logic    [tile_width_lp-1:0]                  bank_resp_tile;
  logic    [data_width_p-1:0]                   bank_resp_data;

  reset_pipe #(
    .reset_depth_p(reset_depth_p)
  ) rst_pipe (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .rst_n_o(row_rst_n)
  );

  for (genvar t = 0; t < num_tiles_p; t++) begin : tile
    tile_endpoint #(
      .tile_id_p   (t),
      .num_tiles_p (num_tiles_p),
      .data_width_p(data_width_p),
      .dmem_words_p(dmem_words_p)
    ) ep (
      .clk_i           (clk_i),
      .rst_n_i         (row_rst_n),
      .req_v_i         (req_v_i[t]),
      .req_op_i        (req_op_i[t]),
      .req_addr_i      (req_addr_i[t]),
      .req_data_i      (req_data_i[t]),
      .busy_o          (busy_o[t]),
      .wait_o          (tile_wait[t]),
      .grant_i         (tile_grant[t]),
      .pend_op_o       (pend_op[t]),
      .pend_addr_o     (pend_addr[t]),
      .pend_data_o     (pend_data[t]),
      .bank_resp_v_i   (bank_resp_v),
      .bank_resp_tile_i(bank_resp_tile),
      .bank_resp_data_i(bank_resp_data),
      .resp_v_o        (resp_v_o[t]),
      .resp_data_o     (resp_data_o[t])
    );
  end

  rr_arbiter #(
    .num_tiles_p (num_tiles_p),
    .data_width_p(data_width_p),
    .dmem_words_p(dmem_words_p)
  ) arb (
    .clk_i      (clk_i),
    .rst_n_i    (row_rst_n),
    .enable_i   (bank_ready),
    .wait_i     (tile_wait),
    .grant_o    (tile_grant),
    .pend_op_i  (pend_op),
    .pend_addr_i(pend_addr),
    .pend_data_i(pend_data),
    .bank_v_o   (bank_v),
    .bank_op_o  (bank_op),
    .bank_addr_o(bank_addr),
    .bank_data_o(bank_data),
    .bank_tile_o(bank_tile)
  );

  mem_bank #(
    .num_tiles_p (num_tiles_p),
    .data_width_p(data_width_p),
    .dmem_words_p(dmem_words_p)
  ) bank (
    .clk_i      (clk_i),
    .rst_n_i    (row_rst_n),
    .bank_v_i   (bank_v),
    .bank_op_i  (bank_op),
    .bank_addr_i(bank_addr),
    .bank_data_i(bank_data),
    .bank_tile_i(bank_tile),
    .ready_o    (bank_ready),
    .resp_v_o   (bank_resp_v),
    .resp_tile_o(bank_resp_tile),
    .resp_data_o(bank_resp_data)
  );

endmodule

`default_nettype wire

// File: sim/tb_vectors.svh
// directed stimulus table for the manycore row testbench with expected responses
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
  int                       tile;
  e_mem_op                  op;
  logic [addr_width_lp-1:0] addr;
  logic [data_width_lp-1:0] data;
  logic [data_width_lp-1:0] resp_exp;
} vec_t;

localparam int vec_count_lp = 12;

// columns: tile, opcode, address, request data, expected response
localparam vec_t vec_table [vec_count_lp] = '{
  // cleared words read back as zero
  '{0, op_load,    4'h3, 32'h0000_0000, 32'h0000_0000},
  '{1, op_load,    4'hf, 32'h0000_0000, 32'h0000_0000},
  '{2, op_store,   4'h3, 32'h1234_5678, 32'h1234_5678},
  '{3, op_load,    4'h3, 32'h0000_0000, 32'h1234_5678},
  // amo add hands back the word before the add
  '{0, op_amo_add, 4'h3, 32'h0000_0010, 32'h1234_5678},
  '{1, op_load,    4'h3, 32'h0000_0000, 32'h1234_5688},
  '{2, op_store,   4'h7, 32'hdead_beef, 32'hdead_beef},
  '{3, op_amo_add, 4'h7, 32'h2000_0001, 32'hdead_beef},
  '{0, op_amo_add, 4'h7, 32'h0000_0010, 32'hfead_bef0},
  '{1, op_load,    4'h7, 32'h0000_0000, 32'hfead_bf00},
  '{2, op_amo_add, 4'h9, 32'h0000_0005, 32'h0000_0000},
  '{3, op_load,    4'h9, 32'h0000_0000, 32'h0000_0005}
};

`endif

// File: sim/tb_manycore_row.sv
// testbench for the manycore row with a directed table, an ignored strobe, a shared amo add and random stores
`timescale 1ns/1ps
`default_nettype none

module tb_manycore_row
  import manycore_cfg_pkg::*;
  import mem_op_pkg::*;
();

  localparam int num_tiles_lp   = num_tiles_default;
  localparam int data_width_lp  = data_width_default;
  localparam int dmem_words_lp  = dmem_words_default;
  localparam int reset_depth_lp = reset_depth_default;
  localparam int addr_width_lp  = safe_clog2(dmem_words_lp);

  `include "tb_vectors.svh"

  // strobe test 3, shared amo 3, random stores 2
  localparam int rounds_lp          = 8;
  localparam int reset_cycles_lp    = 16 + dmem_words_lp + reset_depth_lp + 2;
  localparam int watchdog_cycles_lp =
    (vec_count_lp + rounds_lp) * (num_tiles_lp + 4) + reset_cycles_lp;
  localparam int seed_lp            = 56;

  logic                                          clk_i;
  logic                                          rst_n_i;
  logic    [num_tiles_lp-1:0]                    req_v;
  e_mem_op [num_tiles_lp-1:0]                    req_op;
  logic    [num_tiles_lp-1:0][addr_width_lp-1:0] req_addr;
  logic    [num_tiles_lp-1:0][data_width_lp-1:0] req_data;
  logic    [num_tiles_lp-1:0]                    busy;
  logic    [num_tiles_lp-1:0]                    resp_v;
  logic    [num_tiles_lp-1:0][data_width_lp-1:0] resp_data;

  // one round of requests with at most one per tile
  logic    [num_tiles_lp-1:0] round_v;
  e_mem_op                    round_op   [num_tiles_lp];
  logic    [addr_width_lp-1:0] round_addr [num_tiles_lp];
  logic    [data_width_lp-1:0] round_data [num_tiles_lp];
  logic    [data_width_lp-1:0] round_alt  [num_tiles_lp];
  logic    [data_width_lp-1:0] round_resp [num_tiles_lp];
  int                          round_lat  [num_tiles_lp];
  int                          round_order [$];

  // reference copy of the bank contents
  logic [data_width_lp-1:0] ref_mem [dmem_words_lp];

  manycore_row_top #(
    .num_tiles_p  (num_tiles_lp),
    .data_width_p (data_width_lp),
    .dmem_words_p (dmem_words_lp),
    .reset_depth_p(reset_depth_lp)
  ) dut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_v_i    (req_v),
    .req_op_i   (req_op),
    .req_addr_i (req_addr),
    .req_data_i (req_data),
    .busy_o     (busy),
    .resp_v_o   (resp_v),
    .resp_data_o(resp_data)
  );

  always #5 clk_i = ~clk_i;

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%0t: %s", $time, what);
    $display("sim failed");
    $fatal(1);
  endtask

  // load returns the word, store the written data, amo add the old word
  function automatic logic [data_width_lp-1:0] ref_access(input e_mem_op op,
      input logic [addr_width_lp-1:0] addr, input logic [data_width_lp-1:0] data);
    logic [data_width_lp-1:0] old_word;
    logic [data_width_lp-1:0] result;
    old_word = ref_mem[addr];
    result   = old_word;
    if (op == op_store) begin
      ref_mem[addr] = data;
      result        = data;
    end else if (op == op_amo_add) begin
      ref_mem[addr] = old_word + data;
    end
    return result;
  endfunction

  task automatic clear_round();
    for (int k = 0; k < num_tiles_lp; k++) begin
      round_v[k]    = 1'b0;
      round_op[k]   = op_load;
      round_addr[k] = '0;
      round_data[k] = '0;
      round_alt[k]  = '0;
    end
  endtask

  // issue the round in one cycle and collect one response per active tile
  task automatic apply_round(input bit strobe_again);
    logic [num_tiles_lp-1:0] got;
    int                      edges;
    got   = '0;
    edges = 0;
    round_order.delete();
    @(posedge clk_i);
    for (int k = 0; k < num_tiles_lp; k++) begin
      if (round_v[k]) begin
        req_v[k]    <= 1'b1;
        req_op[k]   <= round_op[k];
        req_addr[k] <= round_addr[k];
        req_data[k] <= round_data[k];
      end
    end
    // acceptance edge
    @(posedge clk_i);
    if (strobe_again) begin
      // request stays up one more cycle with other data while the tiles are busy
      for (int k = 0; k < num_tiles_lp; k++) begin
        if (round_v[k]) begin
          req_data[k] <= round_alt[k];
        end
      end
    end else begin
      req_v <= '0;
    end
    while (got != round_v) begin
      @(negedge clk_i);
      for (int k = 0; k < num_tiles_lp; k++) begin
        if (edges == 0 && round_v[k]) begin
          assert (busy[k]) else
            report_mismatch($sformatf("busy_o[%0d]", k), 32'd1, 32'(busy[k]));
        end
        if (resp_v[k]) begin
          assert (round_v[k]) else
            report_failure($sformatf("tile %0d responded without a request", k));
          assert (!got[k]) else
            report_failure($sformatf("tile %0d responded twice to one request", k));
          got[k]        = 1'b1;
          round_resp[k] = resp_data[k];
          round_lat[k]  = edges;
          round_order.push_back(k);
        end
      end
      if (got != round_v) begin
        assert (edges < num_tiles_lp + 1) else
          report_failure("a request got no response within the latency bound");
        @(posedge clk_i);
        edges = edges + 1;
        req_v <= '0;
      end
    end
  endtask

  initial begin : watchdog
    repeat (watchdog_cycles_lp) @(posedge clk_i);
    report_failure("the run timed out before all tests finished");
  end

  initial begin : main
    int                       t;
    int                       src;
    logic [data_width_lp-1:0] exp_data;
    logic [data_width_lp-1:0] init_word;
    logic [data_width_lp-1:0] total;
    logic [data_width_lp-1:0] word_a;
    logic [addr_width_lp-1:0] amo_addr;

    void'($urandom(seed_lp));
    clk_i    = 1'b0;
    rst_n_i  = 1'b0;
    req_v    = '0;
    req_addr = '0;
    req_data = '0;
    for (int k = 0; k < num_tiles_lp; k++) begin
      req_op[k] = op_load;
    end
    for (int w = 0; w < dmem_words_lp; w++) begin
      ref_mem[w] = '0;
    end
    clear_round();

    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // reset pipe plus bank clearing
    wait (busy == '0);
    repeat (dmem_words_lp + reset_depth_lp) @(posedge clk_i);
    @(negedge clk_i);
    assert (busy == '0) else report_mismatch("busy_o", 32'd0, 32'(busy));
    assert (resp_v == '0) else report_mismatch("resp_v_o", 32'd0, 32'(resp_v));

    // directed table applied one request at a time
    for (int i = 0; i < vec_count_lp; i++) begin
      clear_round();
      t             = vec_table[i].tile;
      round_v[t]    = 1'b1;
      round_op[t]   = vec_table[i].op;
      round_addr[t] = vec_table[i].addr;
      round_data[t] = vec_table[i].data;
      void'(ref_access(vec_table[i].op, vec_table[i].addr, vec_table[i].data));
      apply_round(1'b0);
      assert (round_resp[t] == vec_table[i].resp_exp) else
        report_mismatch($sformatf("resp_data_o[%0d]", t), vec_table[i].resp_exp,
                        round_resp[t]);
      assert (round_lat[t] == 2) else
        report_mismatch($sformatf("latency of tile %0d", t), 32'd2, round_lat[t]);
    end

    // a strobe while busy must not start a second request
    clear_round();
    word_a        = $urandom;
    round_v[1]    = 1'b1;
    round_op[1]   = op_store;
    round_addr[1] = 4'h5;
    round_data[1] = word_a;
    round_alt[1]  = ~word_a;
    exp_data      = ref_access(op_store, 4'h5, word_a);
    apply_round(1'b1);
    assert (round_resp[1] == exp_data) else
      report_mismatch("resp_data_o[1]", exp_data, round_resp[1]);
    assert (round_lat[1] == 2) else
      report_mismatch("latency of tile 1", 32'd2, round_lat[1]);
    repeat (num_tiles_lp + 4) begin
      @(posedge clk_i);
      @(negedge clk_i);
      assert (resp_v == '0) else
        report_failure("a strobe issued while busy produced a response");
    end
    clear_round();
    round_v[2]    = 1'b1;
    round_op[2]   = op_load;
    round_addr[2] = 4'h5;
    exp_data      = ref_access(op_load, 4'h5, '0);
    apply_round(1'b0);
    assert (round_resp[2] == exp_data) else
      report_mismatch("resp_data_o[2]", exp_data, round_resp[2]);

    // every tile adds to one word in the same cycle
    amo_addr      = 4'hb;
    init_word     = $urandom;
    clear_round();
    round_v[0]    = 1'b1;
    round_op[0]   = op_store;
    round_addr[0] = amo_addr;
    round_data[0] = init_word;
    void'(ref_access(op_store, amo_addr, init_word));
    apply_round(1'b0);
    clear_round();
    total = init_word;
    for (int k = 0; k < num_tiles_lp; k++) begin
      round_v[k]    = 1'b1;
      round_op[k]   = op_amo_add;
      round_addr[k] = amo_addr;
      // odd addends keep consecutive partial sums distinct
      round_data[k] = $urandom | 32'd1;
      total         = total + round_data[k];
    end
    apply_round(1'b0);
    for (int n = 0; n < round_order.size(); n++) begin
      t        = round_order[n];
      exp_data = ref_access(op_amo_add, amo_addr, round_data[t]);
      assert (round_resp[t] == exp_data) else
        report_mismatch($sformatf("resp_data_o[%0d]", t), exp_data, round_resp[t]);
    end
    clear_round();
    round_v[num_tiles_lp-1]    = 1'b1;
    round_op[num_tiles_lp-1]   = op_load;
    round_addr[num_tiles_lp-1] = amo_addr;
    apply_round(1'b0);
    assert (round_resp[num_tiles_lp-1] == total) else
      report_mismatch("resp_data_o after shared amo", total, round_resp[num_tiles_lp-1]);

    // random stores to distinct words followed by crossed loads
    clear_round();
    for (int k = 0; k < num_tiles_lp; k++) begin
      round_v[k]    = 1'b1;
      round_op[k]   = op_store;
      round_addr[k] = addr_width_lp'(dmem_words_lp - num_tiles_lp + k);
      round_data[k] = $urandom;
    end
    apply_round(1'b0);
    for (int k = 0; k < num_tiles_lp; k++) begin
      exp_data = ref_access(op_store, round_addr[k], round_data[k]);
      assert (round_resp[k] == exp_data) else
        report_mismatch($sformatf("resp_data_o[%0d]", k), exp_data, round_resp[k]);
    end
    clear_round();
    for (int k = 0; k < num_tiles_lp; k++) begin
      src           = (k + 1) % num_tiles_lp;
      round_v[k]    = 1'b1;
      round_op[k]   = op_load;
      round_addr[k] = addr_width_lp'(dmem_words_lp - num_tiles_lp + src);
    end
    apply_round(1'b0);
    for (int k = 0; k < num_tiles_lp; k++) begin
      exp_data = ref_access(op_load, round_addr[k], '0);
      assert (round_resp[k] == exp_data) else
        report_mismatch($sformatf("resp_data_o[%0d]", k), exp_data, round_resp[k]);
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+sim
verilog/manycore_cfg_pkg.sv
verilog/mem_op_pkg.sv
verilog/reset_pipe.sv
verilog/tile_endpoint.sv
verilog/rr_arbiter.sv
verilog/mem_bank.sv
verilog/manycore_row_top.sv
sim/tb_manycore_row.sv

// File: run_sim.sh
#!/bin/sh
# build and run the manycore row testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary -j 0 -Wno-fatal -f build.f --top-module tb_manycore_row \
    -Mdir obj_dir -o sim_manycore_row; then
  echo "verilator build failed"
  exit 1
fi

obj_dir/sim_manycore_row > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$log"; then
  exit 0
fi

echo "pass line not found in $log"
exit 1
